//--- compile.f
fc_char_pkg.sv
fc_mgmt_pkg.sv
fc_tx_lane_map.sv
fc_rx_lane_map.sv
fc_rx_monitor.sv
fc_xcvr_ctrl.sv
fc_xcvr.sv
tb_fc_xcvr.sv

//--- fc_char_pkg.sv
package fc_char_pkg;

  localparam int fc_lanes = 4;  // characters per transmission word

  // one 8b/10b character before encoding
  typedef struct packed {
    logic       k;     // control character flag
    logic [7:0] data;  // decoded byte
  } fc_char_t;

  // ordered set view, code char is sent first so it sits in the low bits
  typedef struct packed {
    logic [26:0] rest;  // chars 3..1
    fc_char_t    code;  // char 0, K28.5 for most sets
  } fc_oset_t;

  // one transmission word, decoded per char or as an ordered set
  typedef union packed {
    fc_char_t [fc_lanes-1:0] chars;  // chars[0] transmitted first
    fc_oset_t                oset;
  } fc_word_u;

  // parallel side of the serdes, tx direction
  typedef struct packed {
    logic [8*fc_lanes-1:0] data;   // byte lane i = char i
    logic [fc_lanes-1:0]   datak;  // k flag per lane
  } fc_phy_tx_t;

  // parallel side of the serdes, rx direction
  typedef struct packed {
    logic [8*fc_lanes-1:0] data;
    logic [fc_lanes-1:0]   datak;
    logic [fc_lanes-1:0]   disperr;     // running disparity error per lane
    logic [fc_lanes-1:0]   errdetect;   // invalid code group per lane
    logic [fc_lanes-1:0]   syncstatus;  // word aligner locked per lane
  } fc_phy_rx_t;

  localparam logic [7:0] k28_5 = 8'hBC;  // comma char
  localparam logic [7:0] d21_4 = 8'h95;
  localparam logic [7:0] d21_5 = 8'hB5;

  // IDLE = K28.5 D21.4 D21.5 D21.5, K28.5 on char 0
  localparam fc_word_u fc_idle_word = {1'b0, d21_5, 1'b0, d21_5,
                                       1'b0, d21_4, 1'b1, k28_5};

endpackage

//--- fc_mgmt_pkg.sv
package fc_mgmt_pkg;

  // local register map, word addresses
  localparam logic [8:0] reg_status        = 9'd0;
  localparam logic [8:0] reg_control       = 9'd1;
  localparam logic [8:0] reg_disperr_cnt   = 9'd2;
  localparam logic [8:0] reg_code_err_cnt  = 9'd3;
  localparam logic [8:0] reg_sync_loss_cnt = 9'd4;
  localparam logic [8:0] reg_idle_cnt      = 9'd5;

  localparam int phy_window_bit = 9;   // set = serdes reconfig space
  localparam int cnt_width      = 16;  // all event counters

  // status word, pll_locked kept at bit 12
  typedef struct packed {
    logic [18:0] pad;
    logic        pll_locked;
    logic [3:0]  disperr;
    logic [3:0]  errdetect;
    logic [3:0]  syncstatus;
  } fc_status_t;

  // control word
  typedef struct packed {
    logic [29:0] pad;
    logic        cnt_clear;  // self clearing
    logic        tx_enable;  // 0 = send IDLE
  } fc_ctrl_t;

  // rx event counters
  typedef struct packed {
    logic [cnt_width-1:0] disperr;
    logic [cnt_width-1:0] code_err;
    logic [cnt_width-1:0] sync_loss;
    logic [cnt_width-1:0] idle;
  } fc_counters_t;

endpackage

//--- fc_rx_lane_map.sv
`timescale 1ns/1ns

module fc_rx_lane_map (
  input  logic                    mgmt_clk,
  input  logic                    rst,
  input  fc_char_pkg::fc_phy_rx_t phy_rx,
  output fc_char_pkg::fc_word_u   rx_data,         // registered word
  output logic                    rx_valid,        // all lanes in sync
  output logic                    rx_word_valid_q  // same flag, to the monitor
);

  fc_char_pkg::fc_word_u rx_word;  // lanes folded back into chars
  logic                  all_sync; // every aligner locked
  logic                  valid_q;

  always_comb begin
    rx_word = '0;
    for (int i = 0; i < fc_char_pkg::fc_lanes; i++) begin
      rx_word.chars[i].data = phy_rx.data[8*i +: 8];  // byte lane i -> char i
      rx_word.chars[i].k    = phy_rx.datak[i];
    end
  end

  assign all_sync = &phy_rx.syncstatus;

  // payload follows the lanes one cycle later
  always_ff @(posedge mgmt_clk) begin
    rx_data <= rx_word;
  end

  always_ff @(posedge mgmt_clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= all_sync;  // lines up with rx_data
    end
  end

  assign rx_valid        = valid_q;
  assign rx_word_valid_q = valid_q;

  // nothing stale may look valid right after reset lets go
  a_no_valid_after_rst: assert property (@(posedge mgmt_clk)
    $fell(rst) |-> !rx_valid)
    else $error("rx_valid high in first cycle after reset");

endmodule

//--- fc_rx_monitor.sv
`timescale 1ns/1ns

module fc_rx_monitor (
  input  logic                       mgmt_clk,
  input  logic                       rst,
  input  fc_char_pkg::fc_phy_rx_t    phy_rx,          // raw lanes, for error flags
  input  fc_char_pkg::fc_word_u      rx_data,         // registered word
  input  logic                       rx_word_valid_q, // registered sync qualifier
  input  logic                       cnt_clear,       // one cycle pulse
  output fc_mgmt_pkg::fc_counters_t  counters
);

  logic valid_prev;  // rx_word_valid_q one cycle back
  logic valid_fell;  // sync just lost
  logic idle_seen;   // IDLE received in sync
  logic [2:0] disperr_inc;
  logic [2:0] code_err_inc;

  // add with clamp at all ones
  function automatic logic [fc_mgmt_pkg::cnt_width-1:0] sat_add(
    input logic [fc_mgmt_pkg::cnt_width-1:0] cnt,
    input logic [2:0]                        inc
  );
    logic [fc_mgmt_pkg::cnt_width:0] sum;
    sum = {1'b0, cnt} + {{(fc_mgmt_pkg::cnt_width-2){1'b0}}, inc};
    return sum[fc_mgmt_pkg::cnt_width] ? '1 : sum[fc_mgmt_pkg::cnt_width-1:0];
  endfunction

  assign disperr_inc  = 3'($countones(phy_rx.disperr));    // lanes in error this cycle
  assign code_err_inc = 3'($countones(phy_rx.errdetect));
  assign valid_fell   = valid_prev & ~rx_word_valid_q;

  // ordered set check on the code char first, then the tail
  assign idle_seen = rx_word_valid_q &&
                     rx_data.oset.code == fc_char_pkg::fc_idle_word.oset.code &&
                     rx_data.oset.rest == fc_char_pkg::fc_idle_word.oset.rest;

  always_ff @(posedge mgmt_clk) begin
    if (rst) begin
      valid_prev <= 1'b0;
    end else begin
      valid_prev <= rx_word_valid_q;
    end
  end

  always_ff @(posedge mgmt_clk) begin
    if (rst || cnt_clear) begin
      counters <= '0;  // clear wins over any event this cycle
    end else begin
      counters.disperr   <= sat_add(counters.disperr, disperr_inc);
      counters.code_err  <= sat_add(counters.code_err, code_err_inc);
      counters.sync_loss <= sat_add(counters.sync_loss, {2'b00, valid_fell});
      counters.idle      <= sat_add(counters.idle, {2'b00, idle_seen});
    end
  end

  // counters only move up unless software cleared them
  a_cnt_monotonic: assert property (@(posedge mgmt_clk) disable iff (rst)
    (!$past(cnt_clear) && !$past(rst)) |->
      (counters.disperr   >= $past(counters.disperr))   &&
      (counters.code_err  >= $past(counters.code_err))  &&
      (counters.sync_loss >= $past(counters.sync_loss)) &&
      (counters.idle      >= $past(counters.idle)))
    else $error("counter went down without cnt_clear");

endmodule

//--- fc_tx_lane_map.sv
`timescale 1ns/1ns

module fc_tx_lane_map (
  input  logic                    mgmt_clk,
  input  logic                    rst,
  input  fc_char_pkg::fc_word_u   tx_data,    // char 0 goes out first
  input  logic                    tx_enable,  // low = IDLE fill
  output fc_char_pkg::fc_phy_tx_t phy_tx
);

  fc_char_pkg::fc_word_u tx_word;  // word chosen for this cycle

  // char i -> byte lane i, k flag -> datak[i]
  function automatic fc_char_pkg::fc_phy_tx_t to_phy(input fc_char_pkg::fc_word_u w);
    fc_char_pkg::fc_phy_tx_t p;
    p = '0;
    for (int i = 0; i < fc_char_pkg::fc_lanes; i++) begin
      p.data[8*i +: 8] = w.chars[i].data;  // byte lane
      p.datak[i]       = w.chars[i].k;     // k lane
    end
    return p;
  endfunction

  always_comb begin
    tx_word = tx_enable ? tx_data : fc_char_pkg::fc_idle_word;  // keep link up when idle
  end

  always_ff @(posedge mgmt_clk) begin
    if (rst) begin
      phy_tx <= to_phy(fc_char_pkg::fc_idle_word);  // never send garbage out of reset
    end else begin
      phy_tx <= to_phy(tx_word);  // one cycle to the serdes
    end
  end

  // serdes must see clean IDLE for as long as reset is held
  a_idle_in_reset: assert property (@(posedge mgmt_clk)
    rst |=> phy_tx == to_phy(fc_char_pkg::fc_idle_word))
    else $error("phy_tx not IDLE during reset");

endmodule

//--- fc_xcvr.sv
`timescale 1ns/1ns

module fc_xcvr (
  input  logic                    mgmt_clk,
  input  logic                    rst,
  // transmit
  input  fc_char_pkg::fc_word_u   tx_data,
  output fc_char_pkg::fc_phy_tx_t phy_tx,
  // receive
  input  fc_char_pkg::fc_phy_rx_t phy_rx,
  input  logic                    pll_locked,
  output fc_char_pkg::fc_word_u   rx_data,
  output logic                    rx_valid,
  // management port
  input  logic [9:0]              mm_address,
  input  logic                    mm_read,
  input  logic                    mm_write,
  input  logic [31:0]             mm_writedata,
  output logic [31:0]             mm_readdata,
  output logic                    mm_waitrequest,
  // serdes reconfig window
  output logic [8:0]              phy_mgmt_address,
  output logic                    phy_mgmt_read,
  output logic                    phy_mgmt_write,
  output logic [31:0]             phy_mgmt_writedata,
  input  logic [31:0]             phy_mgmt_readdata,
  input  logic                    phy_mgmt_waitrequest
);

  logic                      tx_enable;        // from control reg
  logic                      cnt_clear;        // one cycle pulse
  logic                      rx_word_valid_q;  // registered sync, monitor side
  fc_mgmt_pkg::fc_counters_t counters;

  fc_xcvr_ctrl u_ctrl (
    .mgmt_clk             (mgmt_clk),
    .rst                  (rst),
    .mm_address           (mm_address),
    .mm_read              (mm_read),
    .mm_write             (mm_write),
    .mm_writedata         (mm_writedata),
    .mm_readdata          (mm_readdata),
    .mm_waitrequest       (mm_waitrequest),
    .phy_mgmt_address     (phy_mgmt_address),
    .phy_mgmt_read        (phy_mgmt_read),
    .phy_mgmt_write       (phy_mgmt_write),
    .phy_mgmt_writedata   (phy_mgmt_writedata),
    .phy_mgmt_readdata    (phy_mgmt_readdata),
    .phy_mgmt_waitrequest (phy_mgmt_waitrequest),
    .pll_locked           (pll_locked),
    .phy_rx               (phy_rx),
    .counters             (counters),
    .tx_enable            (tx_enable),
    .cnt_clear            (cnt_clear)
  );

  fc_tx_lane_map u_tx_map (
    .mgmt_clk  (mgmt_clk),
    .rst       (rst),
    .tx_data   (tx_data),
    .tx_enable (tx_enable),
    .phy_tx    (phy_tx)
  );

  fc_rx_lane_map u_rx_map (
    .mgmt_clk        (mgmt_clk),
    .rst             (rst),
    .phy_rx          (phy_rx),
    .rx_data         (rx_data),
    .rx_valid        (rx_valid),
    .rx_word_valid_q (rx_word_valid_q)
  );

  fc_rx_monitor u_rx_mon (
    .mgmt_clk        (mgmt_clk),
    .rst             (rst),
    .phy_rx          (phy_rx),           // error flags counted unregistered
    .rx_data         (rx_data),          // IDLE check on the registered word
    .rx_word_valid_q (rx_word_valid_q),
    .cnt_clear       (cnt_clear),
    .counters        (counters)
  );

endmodule

//--- fc_xcvr_ctrl.sv
`timescale 1ns/1ns

module fc_xcvr_ctrl (
  input  logic                       mgmt_clk,
  input  logic                       rst,
  // management port
  input  logic [9:0]                 mm_address,
  input  logic                       mm_read,
  input  logic                       mm_write,
  input  logic [31:0]                mm_writedata,
  output logic [31:0]                mm_readdata,
  output logic                       mm_waitrequest,
  // serdes reconfig window
  output logic [8:0]                 phy_mgmt_address,
  output logic                       phy_mgmt_read,
  output logic                       phy_mgmt_write,
  output logic [31:0]                phy_mgmt_writedata,
  input  logic [31:0]                phy_mgmt_readdata,
  input  logic                       phy_mgmt_waitrequest,
  // status sources
  input  logic                       pll_locked,
  input  fc_char_pkg::fc_phy_rx_t    phy_rx,
  input  fc_mgmt_pkg::fc_counters_t  counters,
  // control outputs
  output logic                       tx_enable,
  output logic                       cnt_clear
);

  logic                    win_sel;      // access goes to the serdes
  logic [8:0]              local_addr;
  logic                    ctrl_wr;
  logic [31:0]             local_rdata;
  fc_mgmt_pkg::fc_ctrl_t   ctrl_q;
  fc_mgmt_pkg::fc_ctrl_t   wr_ctrl;      // write data seen as control fields
  fc_mgmt_pkg::fc_status_t status;

  assign win_sel    = mm_address[fc_mgmt_pkg::phy_window_bit];
  assign local_addr = mm_address[8:0];
  assign wr_ctrl    = mm_writedata;

  // window forwarding, strobes gated so the serdes only sees its own space
  assign phy_mgmt_read      = win_sel ? mm_read : 1'b0;
  assign phy_mgmt_write     = win_sel ? mm_write : 1'b0;
  assign phy_mgmt_address   = win_sel ? mm_address[8:0] : 9'b0;
  assign phy_mgmt_writedata = win_sel ? mm_writedata : 32'b0;
  assign mm_waitrequest     = win_sel ? phy_mgmt_waitrequest : 1'b0;  // local regs never stall

  // live status, not latched
  always_comb begin
    status            = '0;
    status.pll_locked = pll_locked;
    status.disperr    = phy_rx.disperr;
    status.errdetect  = phy_rx.errdetect;
    status.syncstatus = phy_rx.syncstatus;
  end

  // local readback mux
  always_comb begin
    case (local_addr)
      fc_mgmt_pkg::reg_status:        local_rdata = status;
      fc_mgmt_pkg::reg_control:       local_rdata = ctrl_q;
      fc_mgmt_pkg::reg_disperr_cnt:   local_rdata = 32'(counters.disperr);
      fc_mgmt_pkg::reg_code_err_cnt:  local_rdata = 32'(counters.code_err);
      fc_mgmt_pkg::reg_sync_loss_cnt: local_rdata = 32'(counters.sync_loss);
      fc_mgmt_pkg::reg_idle_cnt:      local_rdata = 32'(counters.idle);
      default:                        local_rdata = 32'b0;  // unmapped reads as zero
    endcase
  end

  assign mm_readdata = win_sel ? phy_mgmt_readdata : local_rdata;

  assign ctrl_wr = mm_write && !win_sel && local_addr == fc_mgmt_pkg::reg_control;

  always_ff @(posedge mgmt_clk) begin
    if (rst) begin
      ctrl_q <= '0;  // tx off, IDLE on the line
    end else begin
      ctrl_q.cnt_clear <= 1'b0;  // pulse lasts one cycle
      if (ctrl_wr) begin
        ctrl_q.tx_enable <= wr_ctrl.tx_enable;
        ctrl_q.cnt_clear <= wr_ctrl.cnt_clear;
      end
    end
  end

  assign tx_enable = ctrl_q.tx_enable;
  assign cnt_clear = ctrl_q.cnt_clear;

  // local accesses must never leak into the serdes reconfig space
  a_window_isolated: assert property (@(posedge mgmt_clk) disable iff (rst)
    !mm_address[fc_mgmt_pkg::phy_window_bit] |-> !phy_mgmt_read && !phy_mgmt_write)
    else $error("phy_mgmt strobe outside the reconfig window");

endmodule

//--- fc_xcvr_tests.txt
# T tx_word exp_phy_data exp_phy_datak | R pll phy_data datak disperr errdetect sync exp_word exp_valid
# W addr wdata | Q addr exp_rdata | P window_addr phy_rdata ; all hex, word char i = bits 9i+8..9i
T 000000000 B5B595BC 1
Q 001 00000000
W 001 00000001
T FB8D025BC F73412BC 9
T 220CC4411 44332211 0
W 001 00000000
T FB8D025BC B5B595BC 1
W 001 00000001
R 1 F73412BC 9 0 0 F FB8D025BC 1
R 1 44332211 0 5 7 F 220CC4411 1
R 1 00000000 0 F 1 7 000000000 0
R 1 44332211 0 0 0 F 220CC4411 1
R 1 F73412BC 9 8 0 E FB8D025BC 0
Q 002 00000007
Q 003 00000004
Q 004 00000002
Q 005 00000000
R 1 B5B595BC 1 0 0 F 5AAD52BBC 1
R 1 B5B595BC 1 0 0 F 5AAD52BBC 1
R 1 B5B595BC 1 0 0 7 5AAD52BBC 0
R 1 B5B595BC 1 0 0 F 5AAD52BBC 1
Q 005 00000003
Q 004 00000003
Q 000 0000100F
R 0 00000000 0 0 0 5 000000000 0
Q 000 00000005
Q 004 00000004
W 001 00000003
Q 002 00000000
Q 003 00000000
Q 004 00000000
Q 005 00000000
Q 001 00000001
P 1A5 CAFEF00D
Q 001 00000001

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_fc_xcvr -f compile.f \
  && ./obj_dir/Vtb_fc_xcvr | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
  && echo "simulation ok" \
  || { echo "simulation failed" >&2; exit 1; }

//--- tb_fc_xcvr.sv
`timescale 1ns/1ns

module tb_fc_xcvr;

  localparam logic [31:0] idle_data  = 32'hB5B595BC;  // D21.5 D21.5 D21.4 K28.5 with lane 0 low
  localparam logic [3:0]  idle_datak = 4'h1;          // only the comma lane is K

  logic                    mgmt_clk;
  logic                    rst;
  fc_char_pkg::fc_word_u   tx_data;
  fc_char_pkg::fc_phy_tx_t phy_tx;
  fc_char_pkg::fc_phy_rx_t phy_rx;
  logic                    pll_locked;
  fc_char_pkg::fc_word_u   rx_data;
  logic                    rx_valid;
  logic [9:0]              mm_address;
  logic                    mm_read;
  logic                    mm_write;
  logic [31:0]             mm_writedata;
  logic [31:0]             mm_readdata;
  logic                    mm_waitrequest;
  logic [8:0]              phy_mgmt_address;
  logic                    phy_mgmt_read;
  logic                    phy_mgmt_write;
  logic [31:0]             phy_mgmt_writedata;
  logic [31:0]             phy_mgmt_readdata;
  logic                    phy_mgmt_waitrequest;

  int   seed         = 80;    // filler words
  int   limit_cycles = 0;     // set once the test file is sized
  logic tx_en_model  = 1'b0;  // control bit 0 as last written

  fc_xcvr dut (.*);

  initial begin
    mgmt_clk = 1'b0;
    forever #5 mgmt_clk = ~mgmt_clk;
  end

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic expect_hex(input string name, input logic [35:0] got, input logic [35:0] exp);
    assert (got === exp) else begin
      $display("Fail %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // char i to byte lane i and datak[i] or IDLE while tx is off
  function automatic logic [35:0] lanes_of(input logic [35:0] w, input logic en);
    logic [31:0] data;
    logic [3:0]  datak;
    if (!en) return {idle_data, idle_datak};
    for (int i = 0; i < 4; i++) begin
      data[8*i +: 8] = w[9*i +: 8];  // byte of char i
      datak[i]       = w[9*i + 8];   // its k flag
    end
    return {data, datak};
  endfunction

  task automatic run_tx(input logic [35:0] word, input logic [35:0] exp);
    @(posedge mgmt_clk);
    tx_data <= word;
    @(posedge mgmt_clk);  // sampled by the lane map
    @(negedge mgmt_clk);
    expect_hex("phy_tx.data", phy_tx.data, exp[35:4]);
    expect_hex("phy_tx.datak", phy_tx.datak, exp[3:0]);
  endtask

  task automatic run_rx(input logic pll, input logic [47:0] lanes,
                        input logic [35:0] exp_word, input logic exp_valid);
    @(posedge mgmt_clk);
    pll_locked <= pll;
    phy_rx     <= lanes;
    mm_address <= {1'b0, fc_mgmt_pkg::reg_status};
    mm_read    <= 1'b1;  // status shows the live flags
    @(negedge mgmt_clk);
    // pll_locked at bit 12 over the disperr, errdetect and sync nibbles
    expect_hex("mm_readdata", mm_readdata, {19'd0, pll, lanes[11:0]});
    @(posedge mgmt_clk);
    mm_read          <= 1'b0;
    phy_rx.data      <= '0;  // word and error flags last one cycle
    phy_rx.datak     <= '0;
    phy_rx.disperr   <= '0;
    phy_rx.errdetect <= '0;  // sync level stays
    @(negedge mgmt_clk);
    expect_hex("rx_data", rx_data, exp_word);
    expect_hex("rx_valid", rx_valid, exp_valid);
  endtask

  task automatic write_reg(input logic [9:0] addr, input logic [31:0] data);
    @(posedge mgmt_clk);
    mm_address   <= addr;
    mm_writedata <= data;
    mm_write     <= 1'b1;
    @(negedge mgmt_clk);
    expect_hex("mm_waitrequest", mm_waitrequest, 0);
    expect_hex("phy_mgmt_write", phy_mgmt_write, 0);  // local write stays local
    @(posedge mgmt_clk);  // write lands here
    mm_write <= 1'b0;
    if (!addr[9] && addr[8:0] == fc_mgmt_pkg::reg_control) tx_en_model = data[0];
  endtask

  task automatic read_reg(input logic [9:0] addr, input logic [31:0] exp);
    @(posedge mgmt_clk);
    mm_address <= addr;
    mm_read    <= 1'b1;
    @(negedge mgmt_clk);
    expect_hex("mm_waitrequest", mm_waitrequest, 0);
    expect_hex("phy_mgmt_read", phy_mgmt_read, 0);  // local read stays local
    expect_hex("mm_readdata", mm_readdata, exp);
    @(posedge mgmt_clk);
    mm_read <= 1'b0;
  endtask

  task automatic window_access(input logic [8:0] addr, input logic [31:0] rdata);
    logic [31:0] wdata;
    wdata = ~rdata;
    @(posedge mgmt_clk);
    mm_address           <= {1'b1, addr};
    mm_read              <= 1'b1;
    phy_mgmt_readdata    <= rdata;
    phy_mgmt_waitrequest <= 1'b1;  // PHY stalls first
    @(negedge mgmt_clk);
    expect_hex("phy_mgmt_address", phy_mgmt_address, addr);
    expect_hex("phy_mgmt_read", phy_mgmt_read, 1);
    expect_hex("mm_waitrequest", mm_waitrequest, 1);
    @(posedge mgmt_clk);
    phy_mgmt_waitrequest <= 1'b0;
    @(negedge mgmt_clk);
    while (mm_waitrequest) @(negedge mgmt_clk);  // hold read until released
    expect_hex("mm_readdata", mm_readdata, rdata);
    @(posedge mgmt_clk);
    mm_read      <= 1'b0;
    mm_write     <= 1'b1;
    mm_writedata <= wdata;
    @(negedge mgmt_clk);
    expect_hex("phy_mgmt_write", phy_mgmt_write, 1);
    expect_hex("phy_mgmt_read", phy_mgmt_read, 0);
    expect_hex("phy_mgmt_writedata", phy_mgmt_writedata, wdata);
    @(posedge mgmt_clk);
    mm_write   <= 1'b0;
    mm_address <= '0;
  endtask

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge mgmt_clk);
    $display("timeout, tests did not finish within %0d cycles", limit_cycles);
    stop_with_failure();
  end

  initial begin : main
    int          fd;
    int          ch;
    int          n;
    int          cnt;
    int          lines;
    logic [7:0]  op;
    logic [35:0] f [0:7];
    logic [63:0] filler;
    rst                  = 1'b1;
    tx_data              = '0;
    phy_rx               = '0;
    pll_locked           = 1'b0;
    mm_address           = '0;
    mm_read              = 1'b0;
    mm_write             = 1'b0;
    mm_writedata         = '0;
    phy_mgmt_readdata    = '0;
    phy_mgmt_waitrequest = 1'b0;
    lines                = 0;
    fd = $fopen("fc_xcvr_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open fc_xcvr_tests.txt");
      stop_with_failure();
    end
    ch = $fgetc(fd);
    while (ch != -1) begin  // size the run for the watchdog
      if (ch == "\n") lines++;
      ch = $fgetc(fd);
    end
    $fclose(fd);
    limit_cycles = 20 * lines + 100;
    fd = $fopen("fc_xcvr_tests.txt", "r");
    repeat (2) @(posedge mgmt_clk);
    rst <= 1'b0;
    @(negedge mgmt_clk);
    expect_hex("phy_tx.data", phy_tx.data, idle_data);
    expect_hex("phy_tx.datak", phy_tx.datak, idle_datak);
    expect_hex("rx_valid", rx_valid, 0);
    while ($fscanf(fd, " %c", op) == 1) begin
      if (op == "#") begin
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);
      end else begin
        cnt = (op == "T") ? 3 : (op == "R") ? 8 : 2;
        n   = 0;
        for (int i = 0; i < cnt; i++) n += $fscanf(fd, "%h", f[i]);
        if (n != cnt) begin
          $display("test file line for op %c has missing fields", op);
          stop_with_failure();
        end
        case (op)
          "T": begin
            run_tx(f[0], {f[1][31:0], f[2][3:0]});
            filler = {$random(seed), $random(seed)};
            run_tx(filler[35:0], lanes_of(filler[35:0], tx_en_model));
          end
          "R": run_rx(f[0][0], {f[1][31:0], f[2][3:0], f[3][3:0], f[4][3:0], f[5][3:0]},
                      f[6], f[7][0]);
          "W": write_reg(f[0][9:0], f[1][31:0]);
          "Q": read_reg(f[0][9:0], f[1][31:0]);
          "P": window_access(f[0][8:0], f[1][31:0]);
          default: begin
            $display("unknown op %c in test file", op);
            stop_with_failure();
          end
        endcase
      end
    end
    $fclose(fd);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
